//--- hw/clk_if_pkg.sv
/* Shared widths, response codes, register map and bus structs for the VITA-49
   clock interface. Every RTL file refers to these by scoped name. */
`default_nettype none

package clk_if_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////

  // AXI4-Lite data bus, one register per word
  localparam int AXI_DATA_WIDTH = 32;
  // Byte address, enough for 16 words
  localparam int AXI_ADDR_WIDTH = 6;
  // Byte offset inside a 32-bit word
  localparam int ADDR_LSB = 2;
  // One strobe bit per data byte
  localparam int STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // Word index taken from the byte address
  typedef logic [AXI_ADDR_WIDTH-ADDR_LSB-1:0] reg_index_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // Word indices, byte address is index times four
  typedef enum logic [3:0] {
    REG_CTRL     = 4'd0,
    REG_STATUS   = 4'd1,
    REG_TSI_PROG = 4'd2,
    REG_TSI_0    = 4'd3,
    REG_TSF_0_HI = 4'd4,
    REG_TSF_0_LO = 4'd5,
    REG_TSI_1    = 4'd6,
    REG_TSF_1_HI = 4'd7,
    REG_TSF_1_LO = 4'd8
  } reg_index_e;

  // Response codes, only OKAY is ever returned
  typedef logic [1:0] axi_resp_t;
  localparam axi_resp_t RESP_OKAY = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // One register write request, valid for a single cycle
  typedef struct packed {
    logic                      valid;
    reg_index_t                index;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0]     strb;
  } reg_write_t;

  // Uploaded timestamp
  // Integer seconds then 64-bit fractional part split in halves
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] tsi;
    logic [AXI_DATA_WIDTH-1:0] tsf_hi;
    logic [AXI_DATA_WIDTH-1:0] tsf_lo;
  } timestamp_t;

endpackage

`default_nettype wire

//--- hw/axil_write_slave.sv
/* AXI4-Lite write front end. Takes AW and W together and hands one
   register write request per transaction to the register bank. */
`default_nettype none

module axil_write_slave
(
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // Write address channel
  input  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  // Write data channel
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] wdata,
  input  logic [clk_if_pkg::STRB_WIDTH-1:0]     wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  // Write response channel
  output clk_if_pkg::axi_resp_t                 bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  // Request to the register bank
  output clk_if_pkg::reg_write_t                wr_req
);

  //////////////////////////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////////////////////////

  // Shared ready pulse for AW and W
  logic ready_q;
  // Both valids present, idle, no response waiting
  logic accept;
  // Handshake cycle on both channels
  logic beat;

  assign accept = awvalid && wvalid && !ready_q && !bvalid;
  assign beat   = ready_q && awvalid && wvalid;

  // One-cycle pulse after both valids are seen
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ready_q <= 1'b0;
    end
    else
    begin
      ready_q <= accept;
    end
  end

  assign awready = ready_q;
  assign wready  = ready_q;

  //////////////////////////////////////////////////////////////////////
  // Register write request
  //////////////////////////////////////////////////////////////////////

  // Address and data are still held by the master in the beat cycle
  always_comb
  begin
    wr_req.valid = beat;
    wr_req.index = awaddr[clk_if_pkg::AXI_ADDR_WIDTH-1:clk_if_pkg::ADDR_LSB];
    wr_req.data  = wdata;
    wr_req.strb  = wstrb;
  end

  //////////////////////////////////////////////////////////////////////
  // Write response
  //////////////////////////////////////////////////////////////////////

  // Raised one edge after the beat, same edge the register updates
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      bvalid <= 1'b0;
    end
    else if (beat)
    begin
      bvalid <= 1'b1;
    end
    else if (bready)
    begin
      // Master took the response
      bvalid <= 1'b0;
    end
  end

  // Unmapped and read-only words still complete normally
  assign bresp = clk_if_pkg::RESP_OKAY;

  // Response survives back-pressure and blocks the next write meanwhile
  bvalid_hold_a : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid && !ready_q);

endmodule

`default_nettype wire

//--- hw/clk_if_regs.sv
/* Writable registers of the clock interface. Holds the control word and
   the seconds preset, updated byte by byte from write requests. */
`default_nettype none

module clk_if_regs
(
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // One-cycle write request from the write front end
  input  clk_if_pkg::reg_write_t                wr_req,
  // Current register contents
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] ctrl_q,
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] tsi_prog_q
);

  // Replace only the strobed bytes of the old word
  function automatic logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] merge_bytes(
    input logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] old_word,
    input logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] new_word,
    input logic [clk_if_pkg::STRB_WIDTH-1:0]     strb
  );
    logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] result;
    result = old_word;
    for (int i = 0; i < clk_if_pkg::STRB_WIDTH; i++)
    begin
      if (strb[i])
      begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Writable map
  //////////////////////////////////////////////////////////////////////

  // Index hits for the two writable words
  logic hit_ctrl;
  logic hit_tsi_prog;

  assign hit_ctrl     = wr_req.valid && (wr_req.index == clk_if_pkg::REG_CTRL);
  assign hit_tsi_prog = wr_req.valid && (wr_req.index == clk_if_pkg::REG_TSI_PROG);

  // Control word, drives the clock core directly
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_q <= '0;
    end
    else if (hit_ctrl)
    begin
      ctrl_q <= merge_bytes(ctrl_q, wr_req.data, wr_req.strb);
    end
  end

  // Integer-seconds preset
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      tsi_prog_q <= '0;
    end
    else if (hit_tsi_prog)
    begin
      tsi_prog_q <= merge_bytes(tsi_prog_q, wr_req.data, wr_req.strb);
    end
  end

  // Other indices fall through, so read-only words stay untouched

endmodule

`default_nettype wire

//--- hw/axil_read_slave.sv
/* AXI4-Lite read back end. Latches the word index, selects from the
   register map and returns registered read data with OKAY. */
`default_nettype none

module axil_read_slave
(
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // Read address channel
  input  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  // Read data channel
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] rdata,
  output clk_if_pkg::axi_resp_t                 rresp,
  output logic                                  rvalid,
  input  logic                                  rready,
  // Register sources
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] ctrl_q,
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] tsi_prog_q,
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] status,
  input  clk_if_pkg::timestamp_t                ts_0_up,
  input  clk_if_pkg::timestamp_t                ts_1_up
);

  //////////////////////////////////////////////////////////////////////
  // Address acceptance
  //////////////////////////////////////////////////////////////////////

  // Address seen, idle, no data waiting
  logic accept;
  // Handshake cycle on AR
  logic load;
  // Latched word index
  clk_if_pkg::reg_index_t rd_index;
  // Mux output
  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] rd_word;

  assign accept = arvalid && !arready && !rvalid;
  assign load   = arready && arvalid;

  // One-cycle ready pulse
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
    end
    else
    begin
      arready <= accept;
    end
  end

  // Index kept for the mux in the following cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
    begin
      rd_index <= araddr[clk_if_pkg::AXI_ADDR_WIDTH-1:clk_if_pkg::ADDR_LSB];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (rd_index)
      clk_if_pkg::REG_CTRL:     rd_word = ctrl_q;
      clk_if_pkg::REG_STATUS:   rd_word = status;
      clk_if_pkg::REG_TSI_PROG: rd_word = tsi_prog_q;
      clk_if_pkg::REG_TSI_0:    rd_word = ts_0_up.tsi;
      clk_if_pkg::REG_TSF_0_HI: rd_word = ts_0_up.tsf_hi;
      clk_if_pkg::REG_TSF_0_LO: rd_word = ts_0_up.tsf_lo;
      clk_if_pkg::REG_TSI_1:    rd_word = ts_1_up.tsi;
      // Timestamp 1 high half lives at word 7
      clk_if_pkg::REG_TSF_1_HI: rd_word = ts_1_up.tsf_hi;
      clk_if_pkg::REG_TSF_1_LO: rd_word = ts_1_up.tsf_lo;
      // Words 9 to 15 read as zero
      default:                  rd_word = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Read data channel
  //////////////////////////////////////////////////////////////////////

  // Valid rises one edge after the AR handshake
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid <= 1'b0;
    end
    else if (load)
    begin
      rvalid <= 1'b1;
    end
    else if (rready)
    begin
      rvalid <= 1'b0;
    end
  end

  // Data captured once, held until the master takes it
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (load)
    begin
      rdata <= rd_word;
    end
  end

  assign rresp = clk_if_pkg::RESP_OKAY;

  // Data and valid stay put under back-pressure
  rdata_stable_a : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- hw/vita49_clk_if.sv
/* Top of the VITA-49 clock interface. Joins the AXI4-Lite port to the
   write front end, register bank and read back end. */
`default_nettype none

module vita49_clk_if
(
  // Clock and synchronous active-low reset
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  // Write address channel
  input  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
  input  logic                                  S_AXI_AWVALID,
  output logic                                  S_AXI_AWREADY,
  // Write data channel
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
  input  logic [clk_if_pkg::STRB_WIDTH-1:0]     S_AXI_WSTRB,
  input  logic                                  S_AXI_WVALID,
  output logic                                  S_AXI_WREADY,
  // Write response channel
  output clk_if_pkg::axi_resp_t                 S_AXI_BRESP,
  output logic                                  S_AXI_BVALID,
  input  logic                                  S_AXI_BREADY,
  // Read address channel
  input  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
  input  logic                                  S_AXI_ARVALID,
  output logic                                  S_AXI_ARREADY,
  // Read data channel
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] S_AXI_RDATA,
  output clk_if_pkg::axi_resp_t                 S_AXI_RRESP,
  output logic                                  S_AXI_RVALID,
  input  logic                                  S_AXI_RREADY,
  // Clock core side
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] ctrl,
  input  logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] status,
  output logic [clk_if_pkg::AXI_DATA_WIDTH-1:0] tsi_prog,
  input  clk_if_pkg::timestamp_t                ts_0_up,
  input  clk_if_pkg::timestamp_t                ts_1_up
);

  // Write request, producer to register bank
  clk_if_pkg::reg_write_t wr_req;

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  axil_write_slave axil_write_slave_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr_req        (wr_req)
  );

  // Register outputs go straight to the clock core
  clk_if_regs clk_if_regs_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_req        (wr_req),
    .ctrl_q        (ctrl),
    .tsi_prog_q    (tsi_prog)
  );

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  axil_read_slave axil_read_slave_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .ctrl_q        (ctrl),
    .tsi_prog_q    (tsi_prog),
    .status        (status),
    .ts_0_up       (ts_0_up),
    .ts_1_up       (ts_1_up)
  );

endmodule

`default_nettype wire

//--- tb/tb_axil_tasks.svh
/* AXI4-Lite master tasks, value check and test table with its register model.
   Included inside the testbench top module after the bus signals. */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

  // One table entry, read or write with expected results
  typedef struct packed {
    logic                                  is_write;
    logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] addr;
    logic [31:0]                           data;
    logic [3:0]                            strb;
    logic [31:0]                           exp_data;
    logic [31:0]                           exp_ctrl;
    logic [31:0]                           exp_tsi;
  } test_entry_t;

  test_entry_t table_q[$];
  string       name_q[$];
  // Model of the two writable words
  logic [31:0] ctrl_model = '0;
  logic [31:0] tsi_model = '0;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // Strobed bytes come from the new word, the rest from the old one
  function automatic logic [31:0] merge_strobed(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Word map as seen by a read
  function automatic logic [31:0] expected_word(input logic [3:0] index);
    case (index)
      4'd0:    return ctrl_model;
      4'd1:    return status;
      4'd2:    return tsi_model;
      4'd3:    return ts_0_up.tsi;
      4'd4:    return ts_0_up.tsf_hi;
      4'd5:    return ts_0_up.tsf_lo;
      4'd6:    return ts_1_up.tsi;
      4'd7:    return ts_1_up.tsf_hi;
      4'd8:    return ts_1_up.tsf_lo;
      default: return 32'h0;
    endcase
  endfunction

  task automatic push_write(input string name, input logic [5:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    test_entry_t entry;
    // Words 0 and 2 are the only writable ones
    if (addr[5:2] == 4'd0)
    begin
      ctrl_model = merge_strobed(ctrl_model, data, strb);
    end
    else if (addr[5:2] == 4'd2)
    begin
      tsi_model = merge_strobed(tsi_model, data, strb);
    end
    entry = '{1'b1, addr, data, strb, 32'h0, ctrl_model, tsi_model};
    table_q.push_back(entry);
    name_q.push_back(name);
  endtask

  task automatic push_read(input string name, input logic [5:0] addr);
    test_entry_t entry;
    entry = '{1'b0, addr, 32'h0, 4'h0, expected_word(addr[5:2]), ctrl_model, tsi_model};
    table_q.push_back(entry);
    name_q.push_back(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // Cleared after reset
    push_read("reset read ctrl", 6'h00);
    push_read("reset read tsi_prog", 6'h08);
    // Full-strobe writes
    push_write("full write ctrl", 6'h00, 32'hA5C3_0F1E, 4'hF);
    push_read("full read ctrl", 6'h00);
    push_write("full write tsi_prog", 6'h08, 32'h5EED_1234, 4'hF);
    push_read("full read tsi_prog", 6'h08);
    // Partial strobes
    push_write("byte 0 write ctrl", 6'h00, 32'h1122_3344, 4'b0001);
    push_read("byte 0 read ctrl", 6'h00);
    push_write("bytes 1 3 write ctrl", 6'h00, 32'h5566_7788, 4'b1010);
    push_read("bytes 1 3 read ctrl", 6'h00);
    push_write("bytes 1 2 write tsi_prog", 6'h08, 32'h99AA_BBCC, 4'b0110);
    push_read("bytes 1 2 read tsi_prog", 6'h08);
    push_write("no strobe write tsi_prog", 6'h08, 32'hFFFF_FFFF, 4'b0000);
    push_read("no strobe read tsi_prog", 6'h08);
    // Status, timestamps, then unmapped words
    for (int w = 1; w < 16; w++)
    begin
      if (w != 2)
      begin
        push_read($sformatf("read word %0d", w), 6'(w * 4));
      end
    end
    // Read-only and unmapped words ignore writes
    for (int w = 1; w < 16; w++)
    begin
      if (w != 2)
      begin
        push_write($sformatf("write word %0d", w), 6'(w * 4), 32'hFFFF_FFFF, 4'hF);
      end
    end
    push_read("final read ctrl", 6'h00);
    push_read("final read tsi_prog", 6'h08);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus transactions, entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic write_word(input string name, input logic [5:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    int delay;
    delay   = int'($urandom_range(3, 0));
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready)
    begin
      @(negedge clk);
    end
    check_value({name, " wready"}, 32'h1, 32'(wready));
    // Handshake on the rising edge in between
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
    begin
      @(negedge clk);
    end
    // Response held under back-pressure
    repeat (delay)
    begin
      @(negedge clk);
      check_value({name, " bvalid held"}, 32'h1, 32'(bvalid));
    end
    // OKAY is code 0
    check_value({name, " bresp"}, 32'h0, 32'(bresp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_value({name, " bvalid drop"}, 32'h0, 32'(bvalid));
  endtask

  task automatic read_word(input string name, input logic [5:0] addr,
                           output logic [31:0] data);
    int delay;
    logic [31:0] first_data;
    delay   = int'($urandom_range(3, 0));
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
    begin
      @(negedge clk);
    end
    first_data = rdata;
    // Valid and data frozen until taken
    repeat (delay)
    begin
      @(negedge clk);
      check_value({name, " rvalid held"}, 32'h1, 32'(rvalid));
      check_value({name, " rdata stable"}, first_data, rdata);
    end
    check_value({name, " rresp"}, 32'h0, 32'(rresp));
    data   = rdata;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_value({name, " rvalid drop"}, 32'h0, 32'(rvalid));
  endtask

`endif

//--- tb/tb_vita49_clk_if.sv
/* Testbench for the VITA-49 clock interface. Runs a table of AXI4-Lite writes
   and reads against a register model and checks every response and output. */
`default_nettype none

module tb_vita49_clk_if;

  // Clock and active-low reset
  logic clk = 1'b0;
  logic rst_n;
  // Write address and data channels
  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] awaddr;
  logic                                  awvalid;
  logic                                  awready;
  logic [31:0]                           wdata;
  logic [3:0]                            wstrb;
  logic                                  wvalid;
  logic                                  wready;
  // Write response channel
  clk_if_pkg::axi_resp_t                 bresp;
  logic                                  bvalid;
  logic                                  bready;
  // Read channels
  logic [clk_if_pkg::AXI_ADDR_WIDTH-1:0] araddr;
  logic                                  arvalid;
  logic                                  arready;
  logic [31:0]                           rdata;
  clk_if_pkg::axi_resp_t                 rresp;
  logic                                  rvalid;
  logic                                  rready;
  // Clock core side
  logic [31:0]                           ctrl;
  logic [31:0]                           status;
  logic [31:0]                           tsi_prog;
  clk_if_pkg::timestamp_t                ts_0_up;
  clk_if_pkg::timestamp_t                ts_1_up;
  // Run limit, set once the table length is known
  int cycle_count = 0;
  int cycle_limit = 1000;

  vita49_clk_if vita49_clk_if_i (
    .S_AXI_ACLK    (clk),
    .S_AXI_ARESETN (rst_n),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready),
    .ctrl          (ctrl),
    .status        (status),
    .tsi_prog      (tsi_prog),
    .ts_0_up       (ts_0_up),
    .ts_1_up       (ts_1_up)
  );

  `include "tb_axil_tasks.svh"

  // 20-unit clock period
  always
  begin
    #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $fatal(1, "simulation stopped by the watchdog");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd_data;
    test_entry_t entry;
    void'($urandom(32'ha939));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    // Clock core inputs stay constant for the whole run
    status         = $urandom();
    ts_0_up.tsi    = $urandom();
    ts_0_up.tsf_hi = $urandom();
    ts_0_up.tsf_lo = $urandom();
    ts_1_up.tsi    = $urandom();
    ts_1_up.tsf_hi = $urandom();
    ts_1_up.tsf_lo = $urandom();
    build_table();
    cycle_limit = 20 * table_q.size() + 50;
    // Reset held over three rising edges
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Idle bus and cleared registers
    check_value("reset ctrl", 32'h0, ctrl);
    check_value("reset tsi_prog", 32'h0, tsi_prog);
    check_value("reset awready", 32'h0, 32'(awready));
    check_value("reset wready", 32'h0, 32'(wready));
    check_value("reset bvalid", 32'h0, 32'(bvalid));
    check_value("reset arready", 32'h0, 32'(arready));
    check_value("reset rvalid", 32'h0, 32'(rvalid));
    foreach (table_q[i])
    begin
      entry = table_q[i];
      if (entry.is_write)
      begin
        write_word(name_q[i], entry.addr, entry.data, entry.strb);
      end
      else
      begin
        read_word(name_q[i], entry.addr, rd_data);
        check_value(name_q[i], entry.exp_data, rd_data);
      end
      // Outputs follow the model after every transaction
      check_value({name_q[i], " ctrl"}, entry.exp_ctrl, ctrl);
      check_value({name_q[i], " tsi_prog"}, entry.exp_tsi, tsi_prog);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
hw/clk_if_pkg.sv
hw/axil_write_slave.sv
hw/clk_if_regs.sv
hw/axil_read_slave.sv
hw/vita49_clk_if.sv
tb/tb_vita49_clk_if.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert -j 0 --top-module tb_vita49_clk_if -f all.f \
  && obj_dir/Vtb_vita49_clk_if | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
